//--- include/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Datapath widths
`define FETCH_PC_W      32
`define FETCH_INST_W    32

// Accepted but not yet delivered fetches
`define FETCH_Q_DEPTH   4

// Instruction memory, word indexed by pc[7:2]
`define IMEM_WORDS      64
`define IMEM_IDX_W      6

// Register map of the configuration block
`define CFG_ADDR_W      12
`define CFG_CTRL        12'h000
`define CFG_VECTOR      12'h004
`define CFG_STATUS      12'h008
`define CFG_IMEM_BASE   12'h100

`define RESET_JUMP_PC   32'hffff_ffff

`endif

//--- logic/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

  // --------------------
  // Fetch datapath types
  // --------------------

  // Instruction address
  typedef logic [`FETCH_PC_W-1:0] pc_t;

  // Raw instruction word
  typedef logic [`FETCH_INST_W-1:0] inst_t;

  // One instruction handed to decode
  typedef struct packed {
    pc_t   pc;
    inst_t inst;
  } fetch_pkt_t;

endpackage

//--- logic/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = `FETCH_Q_DEPTH
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         push,
  input  payload_t                     push_data,
  input  logic                         pop,
  input  logic                         flush,
  output payload_t                     pop_data,
  output logic                         empty,
  output logic [$clog2(depth+1)-1:0]   count
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  payload_t           mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic               full;

  // Wrap at depth, also for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    ptr_inc = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == depth);
  // Show-ahead read of the head entry
  assign pop_data = mem[rd_ptr];

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // Whole queue dropped in one cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push && !flush) mem[wr_ptr] <= push_data;
  end

  // Caller must leave room, and never read an empty queue
  a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
    (push && full) |-> (pop || flush));
  a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
    pop |-> !empty);

endmodule

//--- logic/inst_mem.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module inst_mem (
  input  logic                       clk,
  input  logic                       rstn,
  // Fetch read port
  input  logic                       cmd_valid,
  input  fetch_pkg::pc_t             cmd_addr,
  output logic                       cmd_ready,
  output logic                       rsp_valid,
  output fetch_pkg::inst_t           rsp_data,
  // Program write port
  input  logic                       prog_we,
  input  logic [`IMEM_IDX_W-1:0]     prog_idx,
  input  fetch_pkg::inst_t           prog_data
);

  import fetch_pkg::*;

  inst_t                   mem [`IMEM_WORDS];
  logic                    accept;
  logic [`IMEM_IDX_W-1:0]  rd_idx;

  // --------------------
  // Port arbitration
  // --------------------

  // Program write owns the single port for its cycle
  assign cmd_ready = !prog_we;
  assign accept    = cmd_valid && cmd_ready;
  // Word index, wraps every 64 words
  assign rd_idx    = cmd_addr[`IMEM_IDX_W+1:2];

  // Array write and read
  always_ff @(posedge clk) begin
    if (prog_we) mem[prog_idx] <= prog_data;
    if (accept) rsp_data <= mem[rd_idx];
  end

  // One-cycle response strobe
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= accept;
    end
  end

  // Byte offset bits are dropped by the word index
  a_word_aligned: assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid |-> (cmd_addr[1:0] == 2'b00));

endmodule

//--- logic/fetch_cfg_regs.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_cfg_regs (
  input  logic                       clk,
  input  logic                       rstn,
  // Register port
  input  logic                       cfg_wr,
  input  logic                       cfg_rd,
  input  logic [`CFG_ADDR_W-1:0]     cfg_addr,
  input  logic [31:0]                cfg_wdata,
  output logic [31:0]                cfg_rdata,
  // To fetch unit
  output logic                       run,
  output fetch_pkg::pc_t             ctrl_pc,
  output logic                       ctrl_pc_vld,
  // From fetch unit
  input  logic                       fetch_idle,
  input  logic [15:0]                fetch_count,
  // To instruction memory
  output logic                       prog_we,
  output logic [`IMEM_IDX_W-1:0]     prog_idx,
  output fetch_pkg::inst_t           prog_data
);

  import fetch_pkg::*;

  pc_t   vector;
  logic  wr_ctrl;
  logic  wr_vector;
  logic  in_imem_win;

  // --------------------
  // Address decode
  // --------------------

  assign wr_ctrl     = cfg_wr && (cfg_addr == `CFG_CTRL);
  assign wr_vector   = cfg_wr && (cfg_addr == `CFG_VECTOR);
  // 0x100..0x1fc, one word per memory entry
  assign in_imem_win = (cfg_addr >= `CFG_IMEM_BASE) &&
                       (cfg_addr < (`CFG_IMEM_BASE + (`IMEM_WORDS * 4)));

  // Boot/redirect vector goes straight out
  assign ctrl_pc = vector;

  // CTRL and VECTOR, redirect bit self-clears
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      run         <= 1'b0;
      ctrl_pc_vld <= 1'b0;
      vector      <= '0;
    end else begin
      if (wr_ctrl) run <= cfg_wdata[0];
      // One pulse per write with bit 1 set
      ctrl_pc_vld <= wr_ctrl && cfg_wdata[1];
      if (wr_vector) vector <= cfg_wdata;
    end
  end

  // Memory window writes become program pulses
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      prog_we <= 1'b0;
    end else begin
      prog_we <= cfg_wr && in_imem_win;
    end
  end

  // Write payload, byte offset bits dropped
  always_ff @(posedge clk) begin
    if (cfg_wr && in_imem_win) begin
      prog_idx  <= cfg_addr[`IMEM_IDX_W+1:2];
      prog_data <= cfg_wdata;
    end
  end

  // --------------------
  // Read-back
  // --------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_rdata <= '0;
    end else if (cfg_rd) begin
      case (cfg_addr)
        `CFG_CTRL:   cfg_rdata <= {31'b0, run};
        `CFG_VECTOR: cfg_rdata <= vector;
        // Count on top, idle in bit 0
        `CFG_STATUS: cfg_rdata <= {fetch_count, 15'b0, fetch_idle};
        // Memory window is write only
        default:     cfg_rdata <= '0;
      endcase
    end
  end

endmodule

//--- logic/inst_fetch.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module inst_fetch (
  input  logic                  clk,
  input  logic                  rstn,
  // Control side
  input  logic                  run,
  input  fetch_pkg::pc_t        ctrl_pc,
  input  logic                  ctrl_pc_vld,
  // ALU redirect
  input  fetch_pkg::pc_t        alu_pc,
  input  logic                  alu_pc_vld,
  // Instruction memory
  output logic                  cmd_valid,
  output fetch_pkg::pc_t        cmd_addr,
  input  logic                  cmd_ready,
  input  logic                  rsp_valid,
  input  fetch_pkg::inst_t      rsp_data,
  // Decode
  input  logic                  de_stall,
  output fetch_pkg::inst_t      de_inst,
  output fetch_pkg::pc_t        de_pc,
  output logic                  de_inst_vld,
  // ROB
  output fetch_pkg::pc_t        rob_jump_pc,
  // Status
  output logic                  fetch_idle,
  output logic [15:0]           fetch_count
);

  import fetch_pkg::*;

  localparam int cnt_w = $clog2(`FETCH_Q_DEPTH + 1);

  pc_t               pc;
  pc_t               jump_pc_q;
  logic              redirect;
  logic              accept;
  // In-flight PCs
  pc_t               rsp_pc;
  logic              pc_empty;
  logic [cnt_w-1:0]  pc_count;
  // Returned packets
  fetch_pkt_t        rsp_pkt;
  fetch_pkt_t        head_pkt;
  logic              pkt_push;
  logic              pkt_pop;
  logic              pkt_empty;
  logic [cnt_w-1:0]  pkt_count;
  // Old-path responses still to drop
  logic [cnt_w-1:0]  kill_cnt;
  logic [cnt_w:0]    inflight_total;

  assign redirect = ctrl_pc_vld || alu_pc_vld;
  assign accept   = cmd_valid && cmd_ready;

  // --------------------
  // PC and command
  // --------------------

  // Control beats ALU beats sequential
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc <= '0;
    end else if (ctrl_pc_vld) begin
      pc <= ctrl_pc;
    end else if (alu_pc_vld) begin
      pc <= alu_pc;
    end else if (accept) begin
      pc <= pc + 32'd4;
    end
  end

  // Everything accepted and not yet handed to decode
  assign inflight_total = {1'b0, pc_count} + {1'b0, pkt_count};
  // Stop issuing once the packet queue could overflow
  assign cmd_valid = run && (inflight_total < `FETCH_Q_DEPTH);
  assign cmd_addr  = pc;

  fetch_queue #(
    .payload_t (pc_t),
    .depth     (`FETCH_Q_DEPTH)
  ) i_pc_queue (
    .clk       (clk),
    .rstn      (rstn),
    .push      (accept),
    .push_data (pc),
    .pop       (rsp_valid),
    .flush     (1'b0),
    .pop_data  (rsp_pc),
    .empty     (pc_empty),
    .count     (pc_count)
  );

  // --------------------
  // Kill of stale responses
  // --------------------

  // At a redirect, everything still in flight after this edge is old path
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      kill_cnt <= '0;
    end else if (redirect) begin
      kill_cnt <= pc_count + cnt_w'(accept) - cnt_w'(rsp_valid);
    end else if (rsp_valid && (kill_cnt != '0)) begin
      kill_cnt <= kill_cnt - 1'b1;
    end
  end

  // Pair word with its PC, flush wins over push in the redirect cycle
  assign rsp_pkt  = '{pc: rsp_pc, inst: rsp_data};
  assign pkt_push = rsp_valid && (kill_cnt == '0);
  assign pkt_pop  = !de_stall && !pkt_empty;

  fetch_queue #(
    .payload_t (fetch_pkt_t),
    .depth     (`FETCH_Q_DEPTH)
  ) i_pkt_queue (
    .clk       (clk),
    .rstn      (rstn),
    .push      (pkt_push),
    .push_data (rsp_pkt),
    .pop       (pkt_pop),
    .flush     (redirect),
    .pop_data  (head_pkt),
    .empty     (pkt_empty),
    .count     (pkt_count)
  );

  // --------------------
  // Decode output
  // --------------------

  always_ff @(posedge clk) begin
    if (pkt_pop) begin
      de_pc   <= head_pkt.pc;
      de_inst <= head_pkt.inst;
    end
  end

  // No pulse after a redirect cycle, count tracks pulses
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      de_inst_vld <= 1'b0;
      fetch_count <= '0;
    end else begin
      de_inst_vld <= pkt_pop && !redirect;
      if (pkt_pop && !redirect) fetch_count <= fetch_count + 1'b1;
    end
  end

  // Idle when nothing is in flight or queued
  assign fetch_idle = pc_empty && pkt_empty;

  // --------------------
  // ROB jump target
  // --------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      jump_pc_q <= `RESET_JUMP_PC;
    end else if (redirect) begin
      jump_pc_q <= rob_jump_pc;
    end
  end

  // Target visible in the redirect cycle itself
  always_comb begin
    if (ctrl_pc_vld) begin
      rob_jump_pc = ctrl_pc;
    end else if (alu_pc_vld) begin
      rob_jump_pc = alu_pc;
    end else begin
      rob_jump_pc = jump_pc_q;
    end
  end

  a_depth_bound: assert property (@(posedge clk) disable iff (!rstn)
    inflight_total <= `FETCH_Q_DEPTH);
  // Kills only ever cover responses the memory still owes
  a_kill_bound: assert property (@(posedge clk) disable iff (!rstn)
    kill_cnt <= pc_count);

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top (
  input  logic                    clk,
  input  logic                    rstn,
  // Register port
  input  logic                    cfg_wr,
  input  logic                    cfg_rd,
  input  logic [`CFG_ADDR_W-1:0]  cfg_addr,
  input  logic [31:0]             cfg_wdata,
  output logic [31:0]             cfg_rdata,
  // ALU redirect
  input  fetch_pkg::pc_t          alu_pc,
  input  logic                    alu_pc_vld,
  // Decode
  input  logic                    de_stall,
  output fetch_pkg::inst_t        de_inst,
  output fetch_pkg::pc_t          de_pc,
  output logic                    de_inst_vld,
  // ROB and status
  output fetch_pkg::pc_t          rob_jump_pc,
  output logic                    fetch_idle
);

  import fetch_pkg::*;

  // Config to fetch
  logic                    run;
  pc_t                     ctrl_pc;
  logic                    ctrl_pc_vld;
  logic [15:0]             fetch_count;
  // Config to memory
  logic                    prog_we;
  logic [`IMEM_IDX_W-1:0]  prog_idx;
  inst_t                   prog_data;
  // Fetch to memory
  logic                    cmd_valid;
  pc_t                     cmd_addr;
  logic                    cmd_ready;
  logic                    rsp_valid;
  inst_t                   rsp_data;

  fetch_cfg_regs i_fetch_cfg_regs (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_wr      (cfg_wr),
    .cfg_rd      (cfg_rd),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .run         (run),
    .ctrl_pc     (ctrl_pc),
    .ctrl_pc_vld (ctrl_pc_vld),
    .fetch_idle  (fetch_idle),
    .fetch_count (fetch_count),
    .prog_we     (prog_we),
    .prog_idx    (prog_idx),
    .prog_data   (prog_data)
  );

  inst_fetch i_inst_fetch (
    .clk         (clk),
    .rstn        (rstn),
    .run         (run),
    .ctrl_pc     (ctrl_pc),
    .ctrl_pc_vld (ctrl_pc_vld),
    .alu_pc      (alu_pc),
    .alu_pc_vld  (alu_pc_vld),
    .cmd_valid   (cmd_valid),
    .cmd_addr    (cmd_addr),
    .cmd_ready   (cmd_ready),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data),
    .de_stall    (de_stall),
    .de_inst     (de_inst),
    .de_pc       (de_pc),
    .de_inst_vld (de_inst_vld),
    .rob_jump_pc (rob_jump_pc),
    .fetch_idle  (fetch_idle),
    .fetch_count (fetch_count)
  );

  inst_mem i_inst_mem (
    .clk       (clk),
    .rstn      (rstn),
    .cmd_valid (cmd_valid),
    .cmd_addr  (cmd_addr),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .prog_we   (prog_we),
    .prog_idx  (prog_idx),
    .prog_data (prog_data)
  );

endmodule

//--- tb/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb;

  import fetch_pkg::*;

  logic                    clk;
  logic                    rstn;
  logic                    cfg_wr;
  logic                    cfg_rd;
  logic [`CFG_ADDR_W-1:0]  cfg_addr;
  logic [31:0]             cfg_wdata;
  logic [31:0]             cfg_rdata;
  pc_t                     alu_pc;
  logic                    alu_pc_vld;
  logic                    de_stall;
  inst_t                   de_inst;
  pc_t                     de_pc;
  logic                    de_inst_vld;
  pc_t                     rob_jump_pc;
  logic                    fetch_idle;

  // Reference model state
  inst_t        model_mem [`IMEM_WORDS];
  pc_t          exp_pc;
  pc_t          exp_jump;
  pc_t          vector_model;
  logic         ctrl_redir_q;
  int           delivered;
  logic [31:0]  lfsr_state;

  // Error counters, one per source
  int  deliv_errs = 0;
  int  jump_errs = 0;
  int  hold_errs = 0;
  int  check_errs = 0;
  int  timeouts = 0;

  fetch_top i_fetch_top (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_wr      (cfg_wr),
    .cfg_rd      (cfg_rd),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .alu_pc      (alu_pc),
    .alu_pc_vld  (alu_pc_vld),
    .de_stall    (de_stall),
    .de_inst     (de_inst),
    .de_pc       (de_pc),
    .de_inst_vld (de_inst_vld),
    .rob_jump_pc (rob_jump_pc),
    .fetch_idle  (fetch_idle)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hard limit on the whole run
  initial begin
    #200000;
    $display("Simulation time limit reached before the test finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------
  // Reference model
  // --------------------

  // Control redirect lands one cycle after the CTRL write
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      exp_pc       <= '0;
      exp_jump     <= `RESET_JUMP_PC;
      vector_model <= '0;
      ctrl_redir_q <= 1'b0;
      delivered    <= 0;
    end else begin
      ctrl_redir_q <= cfg_wr && (cfg_addr == `CFG_CTRL) && cfg_wdata[1];
      if (cfg_wr && (cfg_addr == `CFG_VECTOR)) vector_model <= cfg_wdata;
      // Control first, then ALU, then next sequential word
      if (ctrl_redir_q) begin
        exp_pc   <= vector_model;
        exp_jump <= vector_model;
      end else if (alu_pc_vld) begin
        exp_pc   <= alu_pc;
        exp_jump <= alu_pc;
      end else if (de_inst_vld) begin
        exp_pc <= exp_pc + 32'd4;
      end
      if (de_inst_vld) delivered <= delivered + 1;
    end
  end

  // Every delivery matches the model PC and word
  a_delivery: assert property (@(posedge clk) disable iff (!rstn)
    de_inst_vld |-> (de_pc == exp_pc) && (de_inst == model_mem[exp_pc[`IMEM_IDX_W+1:2]]))
    else begin
      $display("** Error @ %0t: delivered pc %h inst %h, model pc %h", $time,
               $sampled(de_pc), $sampled(de_inst), $sampled(exp_pc));
      deliv_errs = deliv_errs + 1;
    end

  // Jump target, live in the redirect cycle and held after it
  a_jump_pc: assert property (@(posedge clk) disable iff (!rstn)
    rob_jump_pc == (ctrl_redir_q ? vector_model : (alu_pc_vld ? alu_pc : exp_jump)))
    else begin
      $display("** Error @ %0t: rob_jump_pc %h is wrong", $time, $sampled(rob_jump_pc));
      jump_errs = jump_errs + 1;
    end

  // No pulse after a stall cycle or a redirect cycle
  a_no_pulse: assert property (@(posedge clk) disable iff (!rstn)
    (de_stall || alu_pc_vld || ctrl_redir_q) |=> !de_inst_vld)
    else begin
      $display("** Error @ %0t: de_inst_vld high after stall or redirect", $time);
      hold_errs = hold_errs + 1;
    end

  // --------------------
  // Stimulus helpers
  // --------------------

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic pause_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic write_reg(input logic [`CFG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr <= 1'b0;
  endtask

  // Read data is registered, stable from the next cycle
  task automatic read_reg(input logic [`CFG_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    cfg_rd   <= 1'b1;
    cfg_addr <= addr;
    @(posedge clk);
    cfg_rd <= 1'b0;
    @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic random_stall(input int n);
    logic [31:0] r;
    repeat (n) begin
      @(posedge clk);
      r = lfsr_bits(1);
      de_stall <= r[0];
    end
  endtask

  task automatic pulse_alu(input pc_t target);
    @(posedge clk);
    alu_pc     <= target;
    alu_pc_vld <= 1'b1;
    @(posedge clk);
    alu_pc_vld <= 1'b0;
  endtask

  // ALU pulse lines up with the control pulse from the CTRL write
  task automatic ctrl_with_alu(input pc_t decoy);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= `CFG_CTRL;
    cfg_wdata <= 32'h0000_0003;
    @(posedge clk);
    cfg_wr     <= 1'b0;
    alu_pc     <= decoy;
    alu_pc_vld <= 1'b1;
    @(posedge clk);
    alu_pc_vld <= 1'b0;
  endtask

  task automatic wait_deliveries(input int target, input int max_cycles, input string what);
    int n;
    n = 0;
    while ((delivered < target) && (n < max_cycles)) begin
      @(negedge clk);
      n++;
    end
    if (delivered < target) begin
      $display("Timeout: %s did not finish within %0d cycles", what, max_cycles);
      timeouts++;
    end
  endtask

  task automatic wait_idle(input int max_cycles);
    int n;
    n = 0;
    // Status flag is settled away from the rising edge
    @(negedge clk);
    while (!fetch_idle && (n < max_cycles)) begin
      @(negedge clk);
      n++;
    end
    if (!fetch_idle) begin
      $display("Timeout: fetch unit did not go idle within %0d cycles", max_cycles);
      timeouts++;
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin : main
    logic [31:0]             r;
    logic [31:0]             data;
    pc_t                     tgt;
    logic [`IMEM_IDX_W-1:0]  idx;
    int                      base;
    int                      d0;
    lfsr_state = 32'hf65e789e;
    rstn       = 1'b0;
    cfg_wr     = 1'b0;
    cfg_rd     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    alu_pc     = '0;
    alu_pc_vld = 1'b0;
    de_stall   = 1'b0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;

    // Reset state and status
    @(negedge clk);
    assert (!de_inst_vld && fetch_idle && (rob_jump_pc == `RESET_JUMP_PC)) else begin
      $display("** Error @ %0t: outputs not in reset state", $time);
      check_errs++;
    end
    read_reg(`CFG_STATUS, data);
    assert (data == 32'h0000_0001) else begin
      $display("** Error @ %0t: reset STATUS %h, expected 00000001", $time, data);
      check_errs++;
    end

    // Program load through the memory window
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      r            = lfsr_bits(32);
      model_mem[i] = r;
      write_reg(12'(`CFG_IMEM_BASE + i * 4), r);
      pause_cycles(int'(lfsr_bits(2)));
    end

    // Start near the top so the run wraps
    write_reg(`CFG_VECTOR, 32'h0000_00e0);
    write_reg(`CFG_CTRL, 32'h0000_0003);
    wait_deliveries(80, 400, "sequential fetch");

    // Random decode back-pressure
    random_stall(200);
    @(posedge clk);
    de_stall <= 1'b0;
    @(negedge clk);
    base = delivered;
    wait_deliveries(base + 8, 100, "fetch after back-pressure");

    // ALU redirects under back-pressure
    for (int k = 0; k < 6; k++) begin
      random_stall(4 + int'(lfsr_bits(3)));
      r   = lfsr_bits(30);
      tgt = {r[29:0], 2'b00};
      pulse_alu(tgt);
      de_stall <= 1'b0;
      @(negedge clk);
      base = delivered;
      wait_deliveries(base + 5, 100, "fetch after ALU redirect");
    end

    // Control and ALU redirect together, control wins
    r   = lfsr_bits(30);
    tgt = {r[29:0], 2'b00};
    write_reg(`CFG_VECTOR, tgt);
    r = lfsr_bits(30);
    ctrl_with_alu({r[29:0], 2'b00});
    @(negedge clk);
    base = delivered;
    wait_deliveries(base + 6, 100, "fetch after control redirect");

    // Rewrite words half a memory ahead of the new path
    r   = lfsr_bits(30);
    tgt = {r[29:0], 2'b00};
    pulse_alu(tgt);
    @(posedge clk);
    for (int k = 0; k < 6; k++) begin
      idx            = tgt[`IMEM_IDX_W+1:2] + 6'd32 + 6'(k);
      r              = lfsr_bits(32);
      model_mem[idx] = r;
      write_reg(12'(`CFG_IMEM_BASE + int'(idx) * 4), r);
      pause_cycles(int'(lfsr_bits(1)));
    end
    @(negedge clk);
    base = delivered;
    wait_deliveries(base + 70, 400, "fetch over rewritten words");

    // Stop, drain, then status
    write_reg(`CFG_CTRL, 32'h0000_0000);
    wait_idle(60);
    repeat (2) @(negedge clk);
    d0 = delivered;
    repeat (12) @(negedge clk);
    assert (delivered == d0) else begin
      $display("** Error @ %0t: deliveries continued after stop", $time);
      check_errs++;
    end
    read_reg(`CFG_STATUS, data);
    assert (data == {d0[15:0], 15'b0, 1'b1}) else begin
      $display("** Error @ %0t: STATUS %h, observed %0d deliveries", $time, data, d0);
      check_errs++;
    end

    $display("Errors: delivery %0d, jump %0d, hold %0d, check %0d, timeout %0d (deliveries %0d)",
             deliv_errs, jump_errs, hold_errs, check_errs, timeouts, delivered);
    if ((deliv_errs + jump_errs + hold_errs + check_errs + timeouts) == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
logic/fetch_pkg.sv
logic/fetch_queue.sv
logic/inst_mem.sv
logic/fetch_cfg_regs.sv
logic/inst_fetch.sv
logic/fetch_top.sv
tb/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Mdir obj_dir \
  --top-module fetch_tb -o fetch_sim -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
